// ==== design/branch_unit.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "mips_defs_macros.svh"

module branch_unit (
   input  wire [`MIPS_WORD_W-1:0]   i_pc,
   input  wire [`MIPS_WORD_W-1:0]   i_ext_imm,
   input  wire [`MIPS_WORD_W-1:0]   i_rs_data,
   input  wire                      i_equal,
   input  wire                      i_is_beq,
   input  wire                      i_is_bne,
   input  wire                      i_is_rjump,
   input  wire                      i_pc_src,
   output logic [`MIPS_WORD_W-1:0]  o_brh_addr,
   output logic [`MIPS_WORD_W-1:0]  o_jmp_addr,
   output logic                     o_pc_taken,
   output logic                     o_flush
);

   localparam int SEG_W = `MIPS_WORD_W - `MIPS_JIDX_W - 2;   // pc region bits kept

   // word offset, wraps like the adder in hardware
   assign o_brh_addr = i_pc + {i_ext_imm[`MIPS_WORD_W-3:0], 2'b00};

   assign o_jmp_addr = i_is_rjump ? i_rs_data
                     : {i_pc[`MIPS_WORD_W-1 -: SEG_W], i_ext_imm[`MIPS_JIDX_W-1:0], 2'b00};

   assign o_pc_taken = (i_is_beq & i_equal) | (i_is_bne & ~i_equal);

   assign o_flush = o_pc_taken | i_pc_src;   // drop the slot already fetched

endmodule

`default_nettype wire

// ==== design/ctrl_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "mips_defs_macros.svh"

module ctrl_decoder (
   input  wire isa_pkg::instr_u       i_instr,
   output ctrl_pkg::alu_op_e          o_alu_op,
   output ctrl_pkg::a_sel_e           o_a_sel,
   output ctrl_pkg::b_sel_e           o_b_sel,
   output ctrl_pkg::dst_sel_e         o_dst_sel,
   output logic                       o_mem_rd,
   output logic                       o_mem_wr,
   output logic                       o_wb_en,
   output ctrl_pkg::wb_src_e          o_wb_src,
   output logic [`MIPS_WORD_W-1:0]    o_ext_imm,
   output logic                       o_is_beq,
   output logic                       o_is_bne,
   output logic                       o_is_rjump,
   output logic                       o_pc_src
);

   ctrl_pkg::ext_sel_e ext_sel;
   isa_pkg::funct_e    funct;
   logic               is_jr_jalr;

   assign funct      = i_instr.ir.low.r.funct;
   assign is_jr_jalr = (funct == isa_pkg::FN_JR) || (funct == isa_pkg::FN_JALR);

   always_comb begin
      // defaults match an unknown opcode, nothing written and no jump
      ext_sel    = ctrl_pkg::EXT_SIGN;
      o_alu_op   = ctrl_pkg::ALU_NONE;
      o_a_sel    = ctrl_pkg::A_NONE;
      o_b_sel    = ctrl_pkg::B_EXT;
      o_dst_sel  = ctrl_pkg::DST_RD;
      o_mem_rd   = 1'b0;
      o_mem_wr   = 1'b0;
      o_wb_en    = 1'b0;
      o_wb_src   = ctrl_pkg::WB_ALU;
      o_is_beq   = 1'b0;
      o_is_bne   = 1'b0;
      o_is_rjump = 1'b0;
      o_pc_src   = 1'b0;
      case (i_instr.ir.opcode)
         isa_pkg::OP_J: begin
            ext_sel  = ctrl_pkg::EXT_JIDX;
            o_pc_src = 1'b1;
         end
         isa_pkg::OP_JAL: begin
            ext_sel   = ctrl_pkg::EXT_JIDX;
            o_alu_op  = ctrl_pkg::ALU_JAL;
            o_a_sel   = ctrl_pkg::A_PC;       // return address from pc
            o_dst_sel = ctrl_pkg::DST_R31;
            o_wb_en   = 1'b1;
            o_pc_src  = 1'b1;
         end
         isa_pkg::OP_BEQ: o_is_beq = 1'b1;
         isa_pkg::OP_BNE: o_is_bne = 1'b1;
         isa_pkg::OP_ADDI, isa_pkg::OP_SLTI,
         isa_pkg::OP_ANDI, isa_pkg::OP_ORI, isa_pkg::OP_XORI: begin
            o_a_sel   = ctrl_pkg::A_RS;
            o_dst_sel = ctrl_pkg::DST_RT;
            o_wb_en   = 1'b1;
            case (i_instr.ir.opcode)
               isa_pkg::OP_ADDI: o_alu_op = ctrl_pkg::ALU_ADD;
               isa_pkg::OP_SLTI: o_alu_op = ctrl_pkg::ALU_SLTI;
               isa_pkg::OP_ANDI: o_alu_op = ctrl_pkg::ALU_ANDI;
               isa_pkg::OP_ORI:  o_alu_op = ctrl_pkg::ALU_ORI;
               default:          o_alu_op = ctrl_pkg::ALU_XORI;
            endcase
            // logical immediates are zero extended
            if (i_instr.ir.opcode != isa_pkg::OP_ADDI &&
                i_instr.ir.opcode != isa_pkg::OP_SLTI) begin
               ext_sel = ctrl_pkg::EXT_ZERO;
            end
         end
         isa_pkg::OP_LUI: begin
            ext_sel   = ctrl_pkg::EXT_ZERO;
            o_alu_op  = ctrl_pkg::ALU_LUI;
            o_dst_sel = ctrl_pkg::DST_RT;
            o_wb_en   = 1'b1;
         end
         isa_pkg::OP_LW, isa_pkg::OP_SW: begin
            o_alu_op  = ctrl_pkg::ALU_ADD;    // base + offset
            o_a_sel   = ctrl_pkg::A_RS;
            o_dst_sel = ctrl_pkg::DST_RT;
            o_mem_rd  = (i_instr.ir.opcode == isa_pkg::OP_LW);
            o_mem_wr  = (i_instr.ir.opcode == isa_pkg::OP_SW);
            o_wb_en   = (i_instr.ir.opcode == isa_pkg::OP_LW);
            o_wb_src  = ctrl_pkg::WB_MEM;
         end
         isa_pkg::OP_SPECIAL: begin
            ext_sel  = ctrl_pkg::EXT_SHAMT;
            o_alu_op = ctrl_pkg::ALU_FUNC;
            o_b_sel  = ctrl_pkg::B_RT;
            case (funct)
               isa_pkg::FN_JALR: o_a_sel = ctrl_pkg::A_PC;
               isa_pkg::FN_SLL, isa_pkg::FN_SRL, isa_pkg::FN_SRA: o_a_sel = ctrl_pkg::A_EXT;
               default:          o_a_sel = ctrl_pkg::A_RS;
            endcase
            o_is_rjump = is_jr_jalr;
            o_pc_src   = is_jr_jalr;
            // funct 0 is also the all-zero nop
            o_wb_en    = (funct != isa_pkg::FN_JR) && (funct != isa_pkg::FN_SLL);
         end
         default: ;
      endcase
   end

   always_comb begin
      case (ext_sel)
         ctrl_pkg::EXT_JIDX:
            o_ext_imm = {{(`MIPS_WORD_W-`MIPS_JIDX_W){1'b0}}, i_instr.j.index};
         ctrl_pkg::EXT_SIGN:
            o_ext_imm = {{(`MIPS_WORD_W-`MIPS_IMM_W){i_instr.ir.low.imm[`MIPS_IMM_W-1]}},
                         i_instr.ir.low.imm};
         ctrl_pkg::EXT_ZERO:
            o_ext_imm = {{(`MIPS_WORD_W-`MIPS_IMM_W){1'b0}}, i_instr.ir.low.imm};
         default:
            o_ext_imm = {{(`MIPS_WORD_W-`MIPS_REG_W){1'b0}}, i_instr.ir.low.r.shamt};
      endcase
   end

endmodule

`default_nettype wire

// ==== design/ctrl_pkg.sv ====
`default_nettype none

package ctrl_pkg;

   // FUNC hands the choice to execute, which reads funct
   typedef enum logic [3:0] {
      ALU_NONE = 4'd0,
      ALU_ADD  = 4'd1,
      ALU_SLTI = 4'd2,
      ALU_ANDI = 4'd3,
      ALU_ORI  = 4'd4,
      ALU_XORI = 4'd5,
      ALU_LUI  = 4'd6,
      ALU_JAL  = 4'd7,
      ALU_FUNC = 4'd8
   } alu_op_e;

   typedef enum logic [1:0] {
      A_PC   = 2'd0,   // link address
      A_RS   = 2'd1,
      A_EXT  = 2'd2,   // shift amount
      A_NONE = 2'd3
   } a_sel_e;

   typedef enum logic {
      B_RT  = 1'b0,
      B_EXT = 1'b1
   } b_sel_e;

   typedef enum logic [1:0] {
      DST_RD  = 2'd0,
      DST_RT  = 2'd1,
      DST_R31 = 2'd2
   } dst_sel_e;

   typedef enum logic [1:0] {
      EXT_JIDX  = 2'd0,
      EXT_SIGN  = 2'd1,
      EXT_ZERO  = 2'd2,
      EXT_SHAMT = 2'd3
   } ext_sel_e;

   typedef enum logic {
      WB_ALU = 1'b0,
      WB_MEM = 1'b1
   } wb_src_e;

endpackage

`default_nettype wire

// ==== design/decode_stage.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "mips_defs_macros.svh"

module decode_stage (
   input  wire                         i_clk,
   input  wire                         i_rst,
   input  wire [`MIPS_WORD_W-1:0]      i_pc,
   input  wire isa_pkg::instr_u        i_instr,
   input  wire [`MIPS_WORD_W-1:0]      i_wb_data,
   input  wire [`MIPS_REG_W-1:0]       i_wb_addr,
   input  wire                         i_wb_en,
   input  wire                         i_bubble,
   output logic [`MIPS_WORD_W-1:0]     o_pc,
   output logic [`MIPS_WORD_W-1:0]     o_rs,
   output logic [`MIPS_WORD_W-1:0]     o_rt,
   output logic [`MIPS_WORD_W-1:0]     o_ext_imm,
   output logic [`MIPS_REG_W-1:0]      o_rs_num,
   output logic [`MIPS_REG_W-1:0]      o_rt_num,
   output logic [`MIPS_REG_W-1:0]      o_rd_num,
   output logic [`MIPS_FUNCT_W-1:0]    o_funct,
   output ctrl_pkg::alu_op_e           o_alu_op,
   output ctrl_pkg::a_sel_e            o_a_sel,
   output ctrl_pkg::b_sel_e            o_b_sel,
   output ctrl_pkg::dst_sel_e          o_dst_sel,
   output logic                        o_mem_rd,
   output logic                        o_mem_wr,
   output logic                        o_wb_en,
   output ctrl_pkg::wb_src_e           o_wb_src,
   output logic [`MIPS_WORD_W-1:0]     o_brh_addr,
   output logic [`MIPS_WORD_W-1:0]     o_jmp_addr,
   output logic                        o_pc_taken,
   output logic                        o_pc_src,
   output logic                        o_flush
);

   // decoder outputs
   ctrl_pkg::alu_op_e       alu_op;
   ctrl_pkg::a_sel_e        a_sel;
   ctrl_pkg::b_sel_e        b_sel;
   ctrl_pkg::dst_sel_e      dst_sel;
   ctrl_pkg::wb_src_e       wb_src;
   logic                    mem_rd;
   logic                    mem_wr;
   logic                    wb_en;
   logic [`MIPS_WORD_W-1:0] ext_imm;
   logic                    is_beq;
   logic                    is_bne;
   logic                    is_rjump;

   // register file outputs
   logic [`MIPS_WORD_W-1:0] rs_data;
   logic [`MIPS_WORD_W-1:0] rt_data;
   logic                    equal;

   ctrl_decoder u_ctrl_decoder (
      .i_instr    (i_instr),
      .o_alu_op   (alu_op),
      .o_a_sel    (a_sel),
      .o_b_sel    (b_sel),
      .o_dst_sel  (dst_sel),
      .o_mem_rd   (mem_rd),
      .o_mem_wr   (mem_wr),
      .o_wb_en    (wb_en),
      .o_wb_src   (wb_src),
      .o_ext_imm  (ext_imm),
      .o_is_beq   (is_beq),
      .o_is_bne   (is_bne),
      .o_is_rjump (is_rjump),
      .o_pc_src   (o_pc_src)
   );

   reg_file u_reg_file (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_rs_addr (i_instr.ir.rs),
      .i_rt_addr (i_instr.ir.rt),
      .i_wr_addr (i_wb_addr),      // write port owned by write-back
      .i_wr_data (i_wb_data),
      .i_wr_en   (i_wb_en),
      .o_rs_data (rs_data),
      .o_rt_data (rt_data),
      .o_equal   (equal)
   );

   branch_unit u_branch_unit (
      .i_pc       (i_pc),
      .i_ext_imm  (ext_imm),
      .i_rs_data  (rs_data),
      .i_equal    (equal),
      .i_is_beq   (is_beq),
      .i_is_bne   (is_bne),
      .i_is_rjump (is_rjump),
      .i_pc_src   (o_pc_src),
      .o_brh_addr (o_brh_addr),
      .o_jmp_addr (o_jmp_addr),
      .o_pc_taken (o_pc_taken),
      .o_flush    (o_flush)
   );

   id_ex_latch u_id_ex_latch (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_bubble  (i_bubble),
      .i_pc      (i_pc),
      .i_rs_data (rs_data),
      .i_rt_data (rt_data),
      .i_ext_imm (ext_imm),
      .i_instr   (i_instr),
      .i_alu_op  (alu_op),
      .i_a_sel   (a_sel),
      .i_b_sel   (b_sel),
      .i_dst_sel (dst_sel),
      .i_mem_rd  (mem_rd),
      .i_mem_wr  (mem_wr),
      .i_wb_en   (wb_en),
      .i_wb_src  (wb_src),
      .o_pc      (o_pc),
      .o_rs      (o_rs),
      .o_rt      (o_rt),
      .o_ext_imm (o_ext_imm),
      .o_rs_num  (o_rs_num),
      .o_rt_num  (o_rt_num),
      .o_rd_num  (o_rd_num),
      .o_funct   (o_funct),
      .o_alu_op  (o_alu_op),
      .o_a_sel   (o_a_sel),
      .o_b_sel   (o_b_sel),
      .o_dst_sel (o_dst_sel),
      .o_mem_rd  (o_mem_rd),
      .o_mem_wr  (o_mem_wr),
      .o_wb_en   (o_wb_en),
      .o_wb_src  (o_wb_src)
   );

endmodule

`default_nettype wire

// ==== design/id_ex_latch.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "mips_defs_macros.svh"

module id_ex_latch (
   input  wire                         i_clk,
   input  wire                         i_rst,
   input  wire                         i_bubble,
   input  wire [`MIPS_WORD_W-1:0]      i_pc,
   input  wire [`MIPS_WORD_W-1:0]      i_rs_data,
   input  wire [`MIPS_WORD_W-1:0]      i_rt_data,
   input  wire [`MIPS_WORD_W-1:0]      i_ext_imm,
   input  wire isa_pkg::instr_u        i_instr,
   input  wire ctrl_pkg::alu_op_e      i_alu_op,
   input  wire ctrl_pkg::a_sel_e       i_a_sel,
   input  wire ctrl_pkg::b_sel_e       i_b_sel,
   input  wire ctrl_pkg::dst_sel_e     i_dst_sel,
   input  wire                         i_mem_rd,
   input  wire                         i_mem_wr,
   input  wire                         i_wb_en,
   input  wire ctrl_pkg::wb_src_e      i_wb_src,
   output logic [`MIPS_WORD_W-1:0]     o_pc,
   output logic [`MIPS_WORD_W-1:0]     o_rs,
   output logic [`MIPS_WORD_W-1:0]     o_rt,
   output logic [`MIPS_WORD_W-1:0]     o_ext_imm,
   output logic [`MIPS_REG_W-1:0]      o_rs_num,
   output logic [`MIPS_REG_W-1:0]      o_rt_num,
   output logic [`MIPS_REG_W-1:0]      o_rd_num,
   output logic [`MIPS_FUNCT_W-1:0]    o_funct,
   output ctrl_pkg::alu_op_e           o_alu_op,
   output ctrl_pkg::a_sel_e            o_a_sel,
   output ctrl_pkg::b_sel_e            o_b_sel,
   output ctrl_pkg::dst_sel_e          o_dst_sel,
   output logic                        o_mem_rd,
   output logic                        o_mem_wr,
   output logic                        o_wb_en,
   output ctrl_pkg::wb_src_e           o_wb_src
);

   // operands and register numbers, still captured under a bubble
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_pc      <= '0;
         o_rs      <= '0;
         o_rt      <= '0;
         o_ext_imm <= '0;
         o_rs_num  <= '0;
         o_rt_num  <= '0;
         o_rd_num  <= '0;
         o_funct   <= '0;
      end else begin
         o_pc      <= i_pc;
         o_rs      <= i_rs_data;
         o_rt      <= i_rt_data;
         o_ext_imm <= i_ext_imm;
         o_rs_num  <= i_instr.ir.rs;
         o_rt_num  <= i_instr.ir.rt;
         o_rd_num  <= i_instr.ir.low.r.rd;
         o_funct   <= i_instr.ir.low.r.funct;
      end
   end

   // a bubble turns the slot into a nop for execute onward
   always_ff @(posedge i_clk) begin
      if (i_rst || i_bubble) begin
         o_alu_op  <= ctrl_pkg::ALU_NONE;
         o_a_sel   <= ctrl_pkg::A_PC;
         o_b_sel   <= ctrl_pkg::B_RT;
         o_dst_sel <= ctrl_pkg::DST_RD;
         o_mem_rd  <= 1'b0;
         o_mem_wr  <= 1'b0;
         o_wb_en   <= 1'b0;
         o_wb_src  <= ctrl_pkg::WB_ALU;
      end else begin
         o_alu_op  <= i_alu_op;
         o_a_sel   <= i_a_sel;
         o_b_sel   <= i_b_sel;
         o_dst_sel <= i_dst_sel;
         o_mem_rd  <= i_mem_rd;
         o_mem_wr  <= i_mem_wr;
         o_wb_en   <= i_wb_en;
         o_wb_src  <= i_wb_src;
      end
   end

endmodule

`default_nettype wire

// ==== design/isa_pkg.sv ====
`default_nettype none
`include "mips_defs_macros.svh"

package isa_pkg;

   // major opcodes, standard MIPS encoding
   typedef enum logic [5:0] {
      OP_SPECIAL = 6'd0,
      OP_J       = 6'd2,
      OP_JAL     = 6'd3,
      OP_BEQ     = 6'd4,
      OP_BNE     = 6'd5,
      OP_ADDI    = 6'd8,
      OP_SLTI    = 6'd10,
      OP_ANDI    = 6'd12,
      OP_ORI     = 6'd13,
      OP_XORI    = 6'd14,
      OP_LUI     = 6'd15,
      OP_LW      = 6'd35,
      OP_SW      = 6'd43
   } opcode_e;

   // SPECIAL functs the decode stage looks at, the rest go to execute as is
   typedef enum logic [`MIPS_FUNCT_W-1:0] {
      FN_SLL  = 6'd0,
      FN_SRL  = 6'd2,
      FN_SRA  = 6'd3,
      FN_JR   = 6'd8,
      FN_JALR = 6'd9
   } funct_e;

   // low half of an I/R word, either rd/shamt/funct or the immediate
   typedef union packed {
      struct packed {
         logic [`MIPS_REG_W-1:0] rd;
         logic [`MIPS_REG_W-1:0] shamt;
         funct_e                 funct;
      } r;
      logic [`MIPS_IMM_W-1:0] imm;
   } low_u;

   typedef union packed {
      struct packed {
         opcode_e                opcode;
         logic [`MIPS_REG_W-1:0] rs;
         logic [`MIPS_REG_W-1:0] rt;
         low_u                   low;
      } ir;                               // I and R formats
      struct packed {
         opcode_e                 opcode;
         logic [`MIPS_JIDX_W-1:0] index;
      } j;                                // J and JAL
   } instr_u;

endpackage

`default_nettype wire

// ==== design/mips_defs_macros.svh ====
`ifndef MIPS_DEFS_MACROS_SVH
`define MIPS_DEFS_MACROS_SVH

// datapath and address width
`define MIPS_WORD_W   32

// register index, also the width of shamt
`define MIPS_REG_W    5

// function field of SPECIAL instructions
`define MIPS_FUNCT_W  6

// I-type immediate
`define MIPS_IMM_W    16

// J-type target index
`define MIPS_JIDX_W   26

// register file depth
`define MIPS_NUM_REGS 32

`endif

// ==== design/reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "mips_defs_macros.svh"

module reg_file (
   input  wire                      i_clk,
   input  wire                      i_rst,
   input  wire [`MIPS_REG_W-1:0]    i_rs_addr,
   input  wire [`MIPS_REG_W-1:0]    i_rt_addr,
   input  wire [`MIPS_REG_W-1:0]    i_wr_addr,
   input  wire [`MIPS_WORD_W-1:0]   i_wr_data,
   input  wire                      i_wr_en,
   output logic [`MIPS_WORD_W-1:0]  o_rs_data,
   output logic [`MIPS_WORD_W-1:0]  o_rt_data,
   output logic                     o_equal
);

   logic [`MIPS_WORD_W-1:0] regs [`MIPS_NUM_REGS];

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_wr_en && (i_wr_addr != '0)) begin   // $zero stays read-only
         regs[i_wr_addr] <= i_wr_data;
      end
   end

   // no write-through, a same-cycle write shows up next cycle
   assign o_rs_data = (i_rs_addr == '0) ? '0 : regs[i_rs_addr];
   assign o_rt_data = (i_rt_addr == '0) ? '0 : regs[i_rt_addr];

   assign o_equal = (o_rs_data == o_rt_data);   // feeds beq/bne

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the decode stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -f sim.f --top-module tb_decode_stage \
      -Mdir obj_dir -o vtb_decode_stage; then
   echo "compile failed"
   exit 1
fi

./obj_dir/vtb_decode_stage +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"; then
   exit 1
fi
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi
exit 0

// ==== sim.f ====
+incdir+design
design/isa_pkg.sv
design/ctrl_pkg.sv
design/ctrl_decoder.sv
design/reg_file.sv
design/branch_unit.sv
design/id_ex_latch.sv
design/decode_stage.sv
sim/decode_stage_asserts.sv
sim/tb_decode_stage.sv

// ==== sim/decode_stage_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_stage_asserts (
   input wire                    i_clk,
   input wire                    i_rst,
   input wire                    i_bubble,
   input wire                    i_pc_taken,
   input wire                    i_pc_src,
   input wire                    i_flush,
   input wire                    i_wb_en,
   input wire                    i_mem_rd,
   input wire                    i_mem_wr,
   input wire ctrl_pkg::alu_op_e i_alu_op
);

   int fail_count = 0;   // read by the testbench at the end

   flush_a: assert property (@(posedge i_clk) disable iff (i_rst)
      i_flush == (i_pc_taken || i_pc_src))
   else begin
      fail_count++;
      $error("flush differs from taken or pc_src");
   end

   // bubbled slot must not write anything
   bubble_a: assert property (@(posedge i_clk) disable iff (i_rst)
      i_bubble |=> (!i_wb_en && !i_mem_rd && !i_mem_wr))
   else begin
      fail_count++;
      $error("control active after a bubble");
   end

   reset_a: assert property (@(posedge i_clk)
      i_rst |=> (!i_wb_en && !i_mem_rd && !i_mem_wr && i_alu_op == ctrl_pkg::ALU_NONE))
   else begin
      fail_count++;
      $error("control active after reset");
   end

endmodule

`default_nettype wire

// ==== sim/tb_decode_stage.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "mips_defs_macros.svh"

module tb_decode_stage;

   localparam int TEST_CYCLES = 200;               // summed length of all tests, rounded up
   localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

   logic                        i_clk;
   logic                        i_rst;
   logic [`MIPS_WORD_W-1:0]     i_pc;
   isa_pkg::instr_u             i_instr;
   logic [`MIPS_WORD_W-1:0]     i_wb_data;
   logic [`MIPS_REG_W-1:0]      i_wb_addr;
   logic                        i_wb_en;
   logic                        i_bubble;
   logic [`MIPS_WORD_W-1:0]     o_pc;
   logic [`MIPS_WORD_W-1:0]     o_rs;
   logic [`MIPS_WORD_W-1:0]     o_rt;
   logic [`MIPS_WORD_W-1:0]     o_ext_imm;
   logic [`MIPS_REG_W-1:0]      o_rs_num;
   logic [`MIPS_REG_W-1:0]      o_rt_num;
   logic [`MIPS_REG_W-1:0]      o_rd_num;
   logic [`MIPS_FUNCT_W-1:0]    o_funct;
   ctrl_pkg::alu_op_e           o_alu_op;
   ctrl_pkg::a_sel_e            o_a_sel;
   ctrl_pkg::b_sel_e            o_b_sel;
   ctrl_pkg::dst_sel_e          o_dst_sel;
   logic                        o_mem_rd;
   logic                        o_mem_wr;
   logic                        o_wb_en;
   ctrl_pkg::wb_src_e           o_wb_src;
   logic [`MIPS_WORD_W-1:0]     o_brh_addr;
   logic [`MIPS_WORD_W-1:0]     o_jmp_addr;
   logic                        o_pc_taken;
   logic                        o_pc_src;
   logic                        o_flush;

   logic [`MIPS_WORD_W-1:0]     model [`MIPS_NUM_REGS];   // expected register contents
   integer                      seed;
   int                          cycles;
   int                          word_errs;
   int                          alu_errs;
   int                          sel_errs;
   int                          bit_errs;

   decode_stage u_decode_stage (.*);

   bind decode_stage decode_stage_asserts u_decode_stage_asserts (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_bubble   (i_bubble),
      .i_pc_taken (o_pc_taken),
      .i_pc_src   (o_pc_src),
      .i_flush    (o_flush),
      .i_wb_en    (o_wb_en),
      .i_mem_rd   (o_mem_rd),
      .i_mem_wr   (o_mem_wr),
      .i_alu_op   (o_alu_op)
   );

   initial begin
      i_clk = 1'b0;
      forever #10 i_clk = ~i_clk;
   end

   always @(posedge i_clk) begin
      cycles <= cycles + 1;
      if (cycles == CYCLE_LIMIT) begin
         $display("Timeout: tests still running after %0d cycles", CYCLE_LIMIT);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   function automatic logic [31:0] sext16(input logic [15:0] imm);
      return {{16{imm[15]}}, imm};
   endfunction

   function automatic isa_pkg::instr_u enc_i(input isa_pkg::opcode_e op, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [15:0] imm);
      isa_pkg::instr_u w;
      w.ir.opcode  = op;
      w.ir.rs      = rs;
      w.ir.rt      = rt;
      w.ir.low.imm = imm;
      return w;
   endfunction

   function automatic isa_pkg::instr_u enc_r(input logic [4:0] rs, input logic [4:0] rt,
                                             input logic [4:0] rd, input logic [4:0] shamt,
                                             input isa_pkg::funct_e fn);
      isa_pkg::instr_u w;
      w.ir.opcode      = isa_pkg::OP_SPECIAL;
      w.ir.rs          = rs;
      w.ir.rt          = rt;
      w.ir.low.r.rd    = rd;
      w.ir.low.r.shamt = shamt;
      w.ir.low.r.funct = fn;
      return w;
   endfunction

   function automatic isa_pkg::instr_u enc_j(input isa_pkg::opcode_e op, input logic [25:0] idx);
      isa_pkg::instr_u w;
      w.j.opcode = op;
      w.j.index  = idx;
      return w;
   endfunction

   task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         word_errs++;
         $display("Fail @%0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_alu_op(input ctrl_pkg::alu_op_e got, input ctrl_pkg::alu_op_e exp,
                               input string what);
      if (got !== exp) begin
         alu_errs++;
         $display("Fail @%0t: %s got %s expected %s", $time, what, got.name(), exp.name());
      end
   endtask

   task automatic check_a_sel(input ctrl_pkg::a_sel_e got, input ctrl_pkg::a_sel_e exp,
                              input string what);
      if (got !== exp) begin
         sel_errs++;
         $display("Fail @%0t: %s got %s expected %s", $time, what, got.name(), exp.name());
      end
   endtask

   task automatic check_dst_sel(input ctrl_pkg::dst_sel_e got, input ctrl_pkg::dst_sel_e exp,
                                input string what);
      if (got !== exp) begin
         sel_errs++;
         $display("Fail @%0t: %s got %s expected %s", $time, what, got.name(), exp.name());
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         bit_errs++;
         $display("Fail @%0t: %s got %b expected %b", $time, what, got, exp);
      end
   endtask

   // present an instruction, return where the branch outputs are settled
   task automatic drive(input isa_pkg::instr_u instr, input logic [31:0] pc, input logic bubble);
      @(posedge i_clk);
      i_instr  <= instr;
      i_pc     <= pc;
      i_bubble <= bubble;
      @(negedge i_clk);
   endtask

   task automatic latch_step;
      @(posedge i_clk);
      i_bubble <= 1'b0;   // latch still sees the old value
      @(negedge i_clk);
   endtask

   task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
      @(posedge i_clk);
      i_wb_en   <= 1'b1;
      i_wb_addr <= addr;
      i_wb_data <= data;
   endtask

   task automatic reset_and_regs;
      logic [31:0] rnd;
      check_alu_op(o_alu_op, ctrl_pkg::ALU_NONE, "reset alu_op");
      check_a_sel(o_a_sel, ctrl_pkg::A_PC, "reset a_sel");
      check_dst_sel(o_dst_sel, ctrl_pkg::DST_RD, "reset dst_sel");
      check_bit(o_wb_en, 1'b0, "reset wb_en");
      check_bit(o_mem_rd, 1'b0, "reset mem_rd");
      check_bit(o_mem_wr, 1'b0, "reset mem_wr");
      model[0] = '0;
      for (int r = 1; r < `MIPS_NUM_REGS; r++) begin
         rnd = $random(seed);
         model[r] = rnd;
         write_reg(5'(r), rnd);
      end
      rnd = $random(seed);
      write_reg(5'd0, rnd);   // must be dropped
      @(posedge i_clk);
      i_wb_en <= 1'b0;
      drive(enc_i(isa_pkg::OP_ADDI, 5'd0, 5'd0, 16'h0001), 32'h0, 1'b0);
      latch_step();
      check_word(o_rs, 32'h0, "register 0 read");
      for (int r = 1; r < `MIPS_NUM_REGS; r++) begin
         drive(enc_i(isa_pkg::OP_ADDI, 5'(r), 5'(r), 16'h0), 32'h0, 1'b0);
         latch_step();
         check_word(o_rs, model[r], $sformatf("register %0d read", r));
         check_word(o_rt, model[r], $sformatf("register %0d read on rt", r));
      end
   endtask

   task automatic imm_case(input isa_pkg::opcode_e op, input ctrl_pkg::alu_op_e exp_alu,
                           input ctrl_pkg::a_sel_e exp_a, input logic zero_ext);
      logic [31:0] rnd;
      logic [15:0] imm;
      rnd = $random(seed);
      imm = {1'b1, rnd[14:0]};   // negative, so sign and zero extension differ
      drive(enc_i(op, 5'd11, 5'd12, imm), 32'h100, 1'b0);
      latch_step();
      check_alu_op(o_alu_op, exp_alu, {op.name(), " alu_op"});
      check_a_sel(o_a_sel, exp_a, {op.name(), " a_sel"});
      check_dst_sel(o_dst_sel, ctrl_pkg::DST_RT, {op.name(), " dst_sel"});
      check_bit(o_b_sel, ctrl_pkg::B_EXT, {op.name(), " b_sel"});
      check_bit(o_wb_en, 1'b1, {op.name(), " wb_en"});
      check_word(o_ext_imm, zero_ext ? {16'h0, imm} : sext16(imm), {op.name(), " ext_imm"});
      check_word(o_pc, 32'h100, {op.name(), " pc"});
      check_word(o_rs_num, 32'd11, {op.name(), " rs num"});
      check_word(o_rt_num, 32'd12, {op.name(), " rt num"});
   endtask

   task automatic imm_alu_ops;
      imm_case(isa_pkg::OP_ADDI, ctrl_pkg::ALU_ADD, ctrl_pkg::A_RS, 1'b0);
      imm_case(isa_pkg::OP_SLTI, ctrl_pkg::ALU_SLTI, ctrl_pkg::A_RS, 1'b0);
      imm_case(isa_pkg::OP_ANDI, ctrl_pkg::ALU_ANDI, ctrl_pkg::A_RS, 1'b1);
      imm_case(isa_pkg::OP_ORI, ctrl_pkg::ALU_ORI, ctrl_pkg::A_RS, 1'b1);
      imm_case(isa_pkg::OP_XORI, ctrl_pkg::ALU_XORI, ctrl_pkg::A_RS, 1'b1);
      imm_case(isa_pkg::OP_LUI, ctrl_pkg::ALU_LUI, ctrl_pkg::A_NONE, 1'b1);
   endtask

   task automatic load_store;
      drive(enc_i(isa_pkg::OP_LW, 5'd13, 5'd14, 16'h0010), 32'h200, 1'b0);
      latch_step();
      check_bit(o_mem_rd, 1'b1, "lw mem_rd");
      check_bit(o_wb_en, 1'b1, "lw wb_en");
      check_bit(o_wb_src, ctrl_pkg::WB_MEM, "lw wb_src");
      check_dst_sel(o_dst_sel, ctrl_pkg::DST_RT, "lw dst_sel");
      drive(enc_i(isa_pkg::OP_SW, 5'd13, 5'd14, 16'h0020), 32'h204, 1'b0);
      latch_step();
      check_bit(o_mem_wr, 1'b1, "sw mem_wr");
      check_bit(o_wb_en, 1'b0, "sw wb_en");
   endtask

   task automatic branch_case(input isa_pkg::opcode_e op, input logic [4:0] rs,
                              input logic [4:0] rt);
      logic [31:0] rnd;
      logic [31:0] pc;
      logic        taken;
      rnd   = $random(seed);
      pc    = {rnd[31:2], 2'b00};
      rnd   = $random(seed);
      taken = (op == isa_pkg::OP_BEQ) ? (model[rs] == model[rt]) : (model[rs] != model[rt]);
      drive(enc_i(op, rs, rt, rnd[15:0]), pc, 1'b0);
      check_bit(o_pc_taken, taken, {op.name(), " taken"});
      check_bit(o_flush, taken, {op.name(), " flush"});
      check_word(o_brh_addr, pc + (sext16(rnd[15:0]) << 2), {op.name(), " target"});
   endtask

   task automatic jumps_special;
      logic [31:0] rnd;
      logic [31:0] pc;
      rnd = $random(seed);
      pc  = $random(seed);
      drive(enc_j(isa_pkg::OP_J, rnd[25:0]), pc, 1'b0);
      check_word(o_jmp_addr, {pc[31:28], rnd[25:0], 2'b00}, "j target");
      check_bit(o_pc_src, 1'b1, "j pc_src");
      latch_step();
      check_bit(o_wb_en, 1'b0, "j wb_en");
      drive(enc_j(isa_pkg::OP_JAL, rnd[25:0]), pc, 1'b0);
      check_word(o_jmp_addr, {pc[31:28], rnd[25:0], 2'b00}, "jal target");
      check_bit(o_pc_src, 1'b1, "jal pc_src");
      latch_step();
      check_dst_sel(o_dst_sel, ctrl_pkg::DST_R31, "jal dst_sel");
      check_alu_op(o_alu_op, ctrl_pkg::ALU_JAL, "jal alu_op");
      check_bit(o_wb_en, 1'b1, "jal wb_en");
      drive(enc_r(5'd7, 5'd0, 5'd0, 5'd0, isa_pkg::FN_JR), pc, 1'b0);
      check_word(o_jmp_addr, model[7], "jr target");
      check_bit(o_flush, 1'b1, "jr flush");
      drive(enc_r(5'd8, 5'd0, 5'd31, 5'd0, isa_pkg::FN_JALR), pc, 1'b0);
      check_word(o_jmp_addr, model[8], "jalr target");
      latch_step();
      check_a_sel(o_a_sel, ctrl_pkg::A_PC, "jalr a_sel");
      drive(enc_r(5'd0, 5'd9, 5'd10, rnd[30:26], isa_pkg::FN_SLL), pc, 1'b0);
      check_bit(o_pc_src, 1'b0, "sll pc_src");
      latch_step();
      check_a_sel(o_a_sel, ctrl_pkg::A_EXT, "sll a_sel");
      check_word(o_ext_imm, {27'h0, rnd[30:26]}, "sll shamt");
      check_bit(o_wb_en, 1'b0, "sll wb_en");
      drive(enc_r(5'd0, 5'd9, 5'd10, 5'd3, isa_pkg::FN_SRA), pc, 1'b0);
      latch_step();
      check_bit(o_wb_en, 1'b1, "sra wb_en");
      check_bit(o_b_sel, ctrl_pkg::B_RT, "sra b_sel");
      check_word(o_rd_num, 32'd10, "sra rd num");
      check_word(o_funct, 32'd3, "sra funct");
   endtask

   task automatic bubble_slot;
      logic [31:0] rnd;
      rnd = $random(seed);
      drive(enc_i(isa_pkg::OP_ADDI, 5'd9, 5'd10, rnd[15:0]), 32'h300, 1'b1);
      latch_step();
      check_alu_op(o_alu_op, ctrl_pkg::ALU_NONE, "bubble alu_op");
      check_a_sel(o_a_sel, ctrl_pkg::A_PC, "bubble a_sel");
      check_dst_sel(o_dst_sel, ctrl_pkg::DST_RD, "bubble dst_sel");
      check_bit(o_wb_en, 1'b0, "bubble wb_en");
      check_bit(o_mem_rd, 1'b0, "bubble mem_rd");
      check_bit(o_mem_wr, 1'b0, "bubble mem_wr");
      check_word(o_rs, model[9], "bubble rs data");
      check_word(o_ext_imm, sext16(rnd[15:0]), "bubble ext_imm");
      check_word(o_pc, 32'h300, "bubble pc");
   endtask

   initial begin
      int total;
      seed      = 56;
      cycles    = 0;
      word_errs = 0;
      alu_errs  = 0;
      sel_errs  = 0;
      bit_errs  = 0;
      i_rst     = 1'b1;
      i_pc      = '0;
      i_instr   = '0;
      i_wb_data = '0;
      i_wb_addr = '0;
      i_wb_en   = 1'b0;
      i_bubble  = 1'b0;
      repeat (2) @(posedge i_clk);
      i_rst <= 1'b0;
      @(negedge i_clk);
      reset_and_regs();
      imm_alu_ops();
      load_store();
      branch_case(isa_pkg::OP_BEQ, 5'd3, 5'd3);
      branch_case(isa_pkg::OP_BEQ, 5'd3, 5'd4);
      branch_case(isa_pkg::OP_BNE, 5'd5, 5'd5);
      branch_case(isa_pkg::OP_BNE, 5'd5, 5'd6);
      jumps_special();
      bubble_slot();
      repeat (2) @(posedge i_clk);
      total = word_errs + alu_errs + sel_errs + bit_errs
            + u_decode_stage.u_decode_stage_asserts.fail_count;
      $display("errors: word %0d, alu_op %0d, select %0d, flag %0d, assertion %0d",
               word_errs, alu_errs, sel_errs, bit_errs,
               u_decode_stage.u_decode_stage_asserts.fail_count);
      if (total == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
